// ==== ad9963_rx.f ====
common/ad9963_rx_pkg.sv
rx_align/iq_deframer.sv
rx_align/rx_qual_timer.sv
rx_align/rx_sync_fsm.sv
rtl/rx_sample_fifo.sv
rtl/ad9963_rx.sv
tb/ad9963_rx_tb.sv

// ==== common/ad9963_rx_pkg.sv ====
// ad9963 receive path shared definitions
// converter word and sample widths, lock qualification length,
// sample buffer sizing, sync state encodings and the I/Q sample view

package ad9963_rx_pkg;

  // ************************************************************************
  // data path widths
  // ************************************************************************

  // one converter word, one edge of the 12-bit bus
  localparam int rx_width = 12;
  // paired I/Q sample
  localparam int sample_width = 24;

  // ************************************************************************
  // link qualification
  // ************************************************************************

  // stable frame-phase cycles needed before lock is declared
  localparam int lock_cycles = 8;
  // counter must be able to hold lock_cycles itself
  localparam int qual_cnt_width = $clog2(lock_cycles + 1);
  localparam logic [qual_cnt_width-1:0] lock_count = qual_cnt_width'(lock_cycles);

  // sync fsm state encodings
  localparam logic [1:0] st_hunt    = 2'd0;
  localparam logic [1:0] st_qualify = 2'd1;
  localparam logic [1:0] st_locked  = 2'd2;

  // ************************************************************************
  // sample buffer
  // ************************************************************************

  localparam int fifo_depth = 4;
  localparam int fifo_addr_width = 2;
  // occupancy value of a full buffer, one bit wider than the pointers
  localparam logic [fifo_addr_width:0] fifo_count_full = (fifo_addr_width + 1)'(fifo_depth);

  // raw word as stored and output, or the q/i halves as built by the deframer
  typedef union packed {
    logic [sample_width-1:0] raw;
    struct packed {
      logic [rx_width-1:0] q;
      logic [rx_width-1:0] i;
    } fld;
  } iq_sample_t;

endpackage

// ==== rtl/ad9963_rx.sv ====
// ad9963 receive front end top
// deframes the dual-edge capture words, qualifies link alignment,
// reports lock on adc_status and buffers accepted samples toward
// a valid/ready consumer

`timescale 1ns/1ps

module ad9963_rx (
  input  logic                                 adc_clk,
  input  logic                                 adc_rst,
  // capture cell side
  input  logic [ad9963_rx_pkg::rx_width-1:0]   trx_data_p,
  input  logic [ad9963_rx_pkg::rx_width-1:0]   trx_data_n,
  input  logic                                 trx_iq_p,
  // sample stream out
  output logic                                 out_valid,
  output ad9963_rx_pkg::iq_sample_t            out_data,
  input  logic                                 out_ready,
  // status
  output logic                                 adc_status,
  output logic                                 overflow
);

  // ************************************************************************
  // internal wiring
  // ************************************************************************

  logic                       frame_valid;
  ad9963_rx_pkg::iq_sample_t  frame_sample;
  logic                       frame_phase;
  logic                       qual_done;
  logic                       accept;
  logic                       wr_en;

  // only samples taken while locked enter the buffer
  assign wr_en = frame_valid & accept;

  // edge pairing and slip repair
  iq_deframer i_deframer (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .trx_data_p   (trx_data_p),
    .trx_data_n   (trx_data_n),
    .trx_iq_p     (trx_iq_p),
    .frame_valid  (frame_valid),
    .frame_sample (frame_sample),
    .frame_phase  (frame_phase));

  // stable phase run counter
  rx_qual_timer i_qual_timer (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .frame_valid  (frame_valid),
    .frame_phase  (frame_phase),
    .qual_done    (qual_done));

  // lock decision
  rx_sync_fsm i_sync_fsm (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .frame_valid  (frame_valid),
    .frame_phase  (frame_phase),
    .qual_done    (qual_done),
    .adc_status   (adc_status),
    .accept       (accept));

  // output buffer, drops on back-pressure
  rx_sample_fifo i_sample_fifo (
    .adc_clk      (adc_clk),
    .adc_rst      (adc_rst),
    .wr_en        (wr_en),
    .wr_data      (frame_sample),
    .out_valid    (out_valid),
    .out_data     (out_data),
    .out_ready    (out_ready),
    .overflow     (overflow));

endmodule

// ==== rtl/rx_sample_fifo.sv ====
// receive sample buffer
// four-entry circular buffer with a registered valid/ready output,
// writes into a full buffer are dropped and set a sticky overflow

`timescale 1ns/1ps

module rx_sample_fifo (
  input  logic                       adc_clk,
  input  logic                       adc_rst,
  input  logic                       wr_en,
  input  ad9963_rx_pkg::iq_sample_t  wr_data,
  output logic                       out_valid,
  output ad9963_rx_pkg::iq_sample_t  out_data,
  input  logic                       out_ready,
  output logic                       overflow
);

  // ************************************************************************
  // storage and pointers
  // ************************************************************************

  logic [ad9963_rx_pkg::sample_width-1:0]  mem [ad9963_rx_pkg::fifo_depth];
  logic [ad9963_rx_pkg::fifo_addr_width-1:0] wr_ptr;
  logic [ad9963_rx_pkg::fifo_addr_width-1:0] rd_ptr;
  logic [ad9963_rx_pkg::fifo_addr_width-1:0] rd_ptr_next;
  // occupancy, one bit wider than the pointers
  logic [ad9963_rx_pkg::fifo_addr_width:0]   count;
  // entries stored before this edge that remain after it
  logic [ad9963_rx_pkg::fifo_addr_width:0]   count_kept;
  logic                                      full;
  logic                                      pop;
  logic                                      push;

  assign full        = (count == ad9963_rx_pkg::fifo_count_full);
  assign pop         = out_valid && out_ready;
  // full buffer still takes a write when the head leaves in the same cycle
  assign push        = wr_en && (!full || pop);
  assign rd_ptr_next = pop ? rd_ptr + 1'b1 : rd_ptr;
  assign count_kept  = count - {{ad9963_rx_pkg::fifo_addr_width{1'b0}}, pop};

  // payload, written only at the tail
  always_ff @(posedge adc_clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data.raw;
    end
  end

  // ************************************************************************
  // output stage
  // ************************************************************************

  // registered copy of the head entry, held while ready is low
  always_ff @(posedge adc_clk) begin
    out_data.raw <= mem[rd_ptr_next];
  end

  // control state
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      out_valid <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr_next;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // a newly written entry shows one cycle after its write
      out_valid <= (count_kept != '0);
      // converter cannot stall, lost samples are only flagged
      if (wr_en && !push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the ad9963 receive testbench with verilator
# exit status is the simulation result

cd "$(dirname "$0")"
status=$?
if [ $status -ne 0 ]; then
  echo "cannot enter the project directory"
  exit $status
fi

verilator --binary --timing -j 0 \
  --top-module ad9963_rx_tb \
  -f ad9963_rx.f \
  -o ad9963_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/ad9963_rx_sim
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished cleanly"
exit 0

// ==== rx_align/iq_deframer.sv ====
// iq deframer
// pairs the rising and falling edge words of the capture cells into
// one I/Q sample, repairing a half-cycle edge slip flagged by the
// frame bit, and forwards the registered frame phase

`timescale 1ns/1ps

module iq_deframer (
  input  logic                                 adc_clk,
  input  logic                                 adc_rst,
  // capture cell outputs, rising and falling edge halves
  input  logic [ad9963_rx_pkg::rx_width-1:0]   trx_data_p,
  input  logic [ad9963_rx_pkg::rx_width-1:0]   trx_data_n,
  input  logic                                 trx_iq_p,
  // paired sample out
  output logic                                 frame_valid,
  output ad9963_rx_pkg::iq_sample_t            frame_sample,
  output logic                                 frame_phase
);

  // rising edge word from the previous cycle
  logic [ad9963_rx_pkg::rx_width-1:0] data_p_hold;

  // payload path
  always_ff @(posedge adc_clk) begin
    data_p_hold <= trx_data_p;
    // the falling edge word always belongs to this cycle
    frame_sample.fld.q <= trx_data_n;
    if (trx_iq_p == 1'b1) begin
      // edges aligned, the rising word is from this cycle too
      frame_sample.fld.i <= trx_data_p;
    end else begin
      // rising edge landed a half cycle late
      // take the held rising word
      frame_sample.fld.i <= data_p_hold;
    end
  end

  // control path
  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      frame_valid <= 1'b0;
      frame_phase <= 1'b0;
    end else begin
      // converter runs free, every cycle after reset carries a sample
      frame_valid <= 1'b1;
      // phase copy for the timer and the sync fsm
      frame_phase <= trx_iq_p;
    end
  end

endmodule

// ==== rx_align/rx_qual_timer.sv ====
// link qualification timer
// counts consecutive cycles with an unchanged frame phase and
// raises qual_done once the run reaches the lock threshold

`timescale 1ns/1ps

module rx_qual_timer (
  input  logic adc_clk,
  input  logic adc_rst,
  input  logic frame_valid,
  input  logic frame_phase,
  output logic qual_done
);

  // previous frame phase, for change detection
  logic                                      phase_prev;
  // saturating stable-run counter
  logic [ad9963_rx_pkg::qual_cnt_width-1:0]  stable_cnt;

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      phase_prev <= 1'b0;
      stable_cnt <= '0;
      qual_done  <= 1'b0;
    end else begin
      if (frame_valid) begin
        phase_prev <= frame_phase;
        if (frame_phase != phase_prev) begin
          // any flip restarts the run
          stable_cnt <= '0;
        end else if (stable_cnt != ad9963_rx_pkg::lock_count) begin
          stable_cnt <= stable_cnt + 1'b1;
        end
      end
      // one cycle behind the count
      qual_done <= (stable_cnt == ad9963_rx_pkg::lock_count);
    end
  end

endmodule

// ==== rx_align/rx_sync_fsm.sv ====
// receive sync state machine
// hunt -> qualify -> locked, drops lock on any frame phase flip and
// waits for a fresh qualification before accepting samples again

`timescale 1ns/1ps

module rx_sync_fsm (
  input  logic adc_clk,
  input  logic adc_rst,
  input  logic frame_valid,
  input  logic frame_phase,
  input  logic qual_done,
  output logic adc_status,
  output logic accept
);

  logic [1:0] state;
  // last seen phase, flip detection independent of the timer
  logic       phase_q;
  // previous qual_done, only a fresh rise may lock
  logic       qual_done_q;
  logic       phase_flip;
  logic       qual_rise;

  // a flip is seen directly on frame_phase, one cycle ahead of the timer
  assign phase_flip = frame_valid && (frame_phase != phase_q);
  // qual_done stays high for a couple of cycles after a flip,
  // so lock waits for it to rise again
  assign qual_rise  = qual_done && !qual_done_q;

  always_ff @(posedge adc_clk) begin
    if (adc_rst) begin
      state       <= ad9963_rx_pkg::st_hunt;
      phase_q     <= 1'b0;
      qual_done_q <= 1'b0;
    end else begin
      phase_q     <= frame_phase;
      qual_done_q <= qual_done;
      case (state)
        ad9963_rx_pkg::st_hunt: begin
          // first frame seen, the timer is running from here
          if (frame_valid) begin
            state <= ad9963_rx_pkg::st_qualify;
          end
        end
        ad9963_rx_pkg::st_qualify: begin
          // a flip in the same cycle wins over the rise
          if (qual_rise && !phase_flip) begin
            state <= ad9963_rx_pkg::st_locked;
          end
        end
        ad9963_rx_pkg::st_locked: begin
          if (phase_flip) begin
            state <= ad9963_rx_pkg::st_qualify;
          end
        end
        default: begin
          state <= ad9963_rx_pkg::st_hunt;
        end
      endcase
    end
  end

  // status and sample acceptance both follow the locked state
  assign adc_status = (state == ad9963_rx_pkg::st_locked);
  assign accept     = adc_status;

endmodule

// ==== tb/ad9963_rx_tb.sv ====
// ad9963 receive front end testbench
// directed rows from the cases file, then a random phase with ready
// stalls and frame flag flips, checked each cycle against a reference
// model of the pairing, lock and buffer rules

`timescale 1ns/1ps

module ad9963_rx_tb;

  localparam int clk_period    = 8;
  localparam int num_rows      = 10;
  // repeat, rise word, fall word, flag, ready, expected sample
  localparam int row_words     = 6;
  localparam int rand_cycles   = 240;
  localparam int min_transfers = 20;
  localparam int hunt_st       = 0;
  localparam int qualify_st    = 1;
  localparam int locked_st     = 2;

  logic                                  adc_clk;
  logic                                  adc_rst;
  logic [ad9963_rx_pkg::rx_width-1:0]    trx_data_p;
  logic [ad9963_rx_pkg::rx_width-1:0]    trx_data_n;
  logic                                  trx_iq_p;
  logic                                  out_ready;
  logic                                  out_valid;
  ad9963_rx_pkg::iq_sample_t             out_data;
  logic                                  adc_status;
  logic                                  overflow;

  logic [31:0] rows_mem [num_rows * row_words];
  int          limit_cycles = 0;
  int          transfers = 0;

  // ************************************************************************
  // reference model state
  // ************************************************************************

  // pairing stage
  logic [11:0] m_hold_p;
  logic [23:0] m_sample;
  logic        m_fv;
  logic        m_fp;
  // stable run qualification
  logic        m_prev_phase;
  int          m_run;
  logic        m_qual;
  // lock decision
  logic        m_seen_phase;
  logic        m_qual_d;
  int          m_state;
  // buffer contents in delivery order
  logic [23:0] exp_q [$];
  logic        m_valid;
  logic        m_ovf;

  ad9963_rx uut (
    .adc_clk    (adc_clk),
    .adc_rst    (adc_rst),
    .trx_data_p (trx_data_p),
    .trx_data_n (trx_data_n),
    .trx_iq_p   (trx_iq_p),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_ready  (out_ready),
    .adc_status (adc_status),
    .overflow   (overflow));

  initial begin
    adc_clk = 1'b0;
    forever begin
      #(clk_period / 2) adc_clk = ~adc_clk;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("Fail: time %0t: %s got %h expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "output mismatch");
    end
  endtask

  // advance the model by one clock edge, all next values from old state
  task automatic model_step(input logic rst, input logic [11:0] p, input logic [11:0] n,
                            input logic iq, input logic rdy, input logic use_exp,
                            input logic [23:0] exp_s);
    logic [23:0] nxt_sample;
    logic [23:0] cur_sample;
    logic        qual_old;
    logic        flip;
    logic        rise;
    logic        wr;
    logic        pop;
    logic        push;
    int          kept;
    // aligned edges pair in the same cycle, a slip takes the held rise word
    nxt_sample = iq ? {n, p} : {n, m_hold_p};
    if (use_exp) begin
      nxt_sample = exp_s;
    end
    // the buffer takes the sample paired on the previous edge
    cur_sample = m_sample;
    m_hold_p = p;
    m_sample = nxt_sample;
    if (rst) begin
      m_fv = 1'b0;
      m_fp = 1'b0;
      m_prev_phase = 1'b0;
      m_run = 0;
      m_qual = 1'b0;
      m_seen_phase = 1'b0;
      m_qual_d = 1'b0;
      m_state = hunt_st;
      exp_q.delete();
      m_valid = 1'b0;
      m_ovf = 1'b0;
      return;
    end
    flip = m_fv && (m_fp != m_seen_phase);
    rise = m_qual && !m_qual_d;
    wr   = m_fv && (m_state == locked_st);
    pop  = m_valid && rdy;
    kept = exp_q.size() - (pop ? 1 : 0);
    push = wr && ((exp_q.size() < ad9963_rx_pkg::fifo_depth) || pop);
    if (pop) begin
      void'(exp_q.pop_front());
      transfers++;
    end
    if (push) begin
      exp_q.push_back(cur_sample);
    end
    // a full buffer drops the sample and flags it until reset
    if (wr && !push) begin
      m_ovf = 1'b1;
    end
    m_valid = (kept != 0);
    // qualification follows the run count one cycle late
    qual_old = m_qual;
    m_qual = (m_run == ad9963_rx_pkg::lock_cycles);
    if (m_fv) begin
      if (m_fp != m_prev_phase) begin
        m_run = 0;
      end else if (m_run < ad9963_rx_pkg::lock_cycles) begin
        m_run++;
      end
      m_prev_phase = m_fp;
    end
    case (m_state)
      hunt_st:    m_state = m_fv ? qualify_st : hunt_st;
      qualify_st: m_state = (rise && !flip) ? locked_st : qualify_st;
      default:    m_state = flip ? qualify_st : locked_st;
    endcase
    m_seen_phase = m_fp;
    m_qual_d = qual_old;
    m_fv = 1'b1;
    m_fp = iq;
  endtask

  task automatic compare_outputs();
    check_value(32'(adc_status), 32'(m_state == locked_st), "adc_status");
    check_value(32'(out_valid), 32'(m_valid), "out_valid");
    check_value(32'(overflow), 32'(m_ovf), "overflow");
    // head entry must hold steady through ready stalls
    if (m_valid) begin
      check_value(32'(out_data.raw), 32'(exp_q[0]), "out_data");
    end
  endtask

  // drive one input cycle, then check the outputs just after the edge
  task automatic run_cycle(input logic rst, input logic [11:0] p, input logic [11:0] n,
                           input logic iq, input logic rdy, input logic use_exp,
                           input logic [23:0] exp_s);
    adc_rst    = rst;
    trx_data_p = p;
    trx_data_n = n;
    trx_iq_p   = iq;
    out_ready  = rdy;
    @(posedge adc_clk);
    model_step(rst, p, n, iq, rdy, use_exp, exp_s);
    #1;
    compare_outputs();
  endtask

  // ************************************************************************
  // stimulus
  // ************************************************************************

  initial begin
    int          base;
    int          total;
    logic [31:0] seed;
    logic        rand_iq;
    adc_rst    = 1'b1;
    trx_data_p = '0;
    trx_data_n = '0;
    trx_iq_p   = 1'b0;
    out_ready  = 1'b0;
    $readmemh("tb/rx_cases.txt", rows_mem);
    total = 0;
    for (int r = 0; r < num_rows; r++) begin
      total += int'(rows_mem[r * row_words]);
    end
    // both resets, directed and random cycles, and some slack
    limit_cycles = total + rand_cycles + 4 + 50;

    run_cycle(1'b1, 12'd0, 12'd0, 1'b0, 1'b0, 1'b0, 24'd0);
    run_cycle(1'b1, 12'd0, 12'd0, 1'b0, 1'b0, 1'b0, 24'd0);

    // directed rows, words step by one per repeat
    for (int r = 0; r < num_rows; r++) begin
      base = r * row_words;
      for (int j = 0; j < int'(rows_mem[base]); j++) begin
        run_cycle(1'b0, 12'(rows_mem[base + 1] + 32'(j)), 12'(rows_mem[base + 2] + 32'(j)),
                  rows_mem[base + 3][0], rows_mem[base + 4][0],
                  (j == 0) && !rows_mem[base + 5][24], rows_mem[base + 5][23:0]);
      end
    end
    // the long stall in the rows must have lost samples
    check_value(32'(overflow), 32'd1, "overflow after long stall");

    // only a reset clears the sticky flag
    run_cycle(1'b1, 12'd0, 12'd0, 1'b0, 1'b0, 1'b0, 24'd0);
    run_cycle(1'b1, 12'd0, 12'd0, 1'b0, 1'b0, 1'b0, 24'd0);

    // random words, ready low a quarter of the time, rare flag flips
    transfers = 0;
    seed = 32'h412b9a45;
    rand_iq = 1'b1;
    for (int c = 0; c < rand_cycles; c++) begin
      seed = xorshift(seed);
      if (seed[4:0] == 5'd0) begin
        rand_iq = !rand_iq;
      end
      run_cycle(1'b0, seed[19:8], seed[31:20], rand_iq, seed[7:6] != 2'b00, 1'b0, 24'd0);
    end

    if (transfers < min_transfers) begin
      $display("Result: FAILED");
      $fatal(1, "only %0d samples were delivered", transfers);
    end else begin
      $display("Result: PASSED");
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge adc_clk);
    $display("Result: FAILED");
    $fatal(1, "timeout, the run did not finish within %0d cycles", limit_cycles);
  end

endmodule

// ==== tb/rx_cases.txt ====
// columns: repeat rise_word fall_word frame_flag out_ready expected_sample
// words step by one per repeat, expected is {q,i} of the first cycle, 1000000 is don't care
// lock acquisition with the flag high
10 100 200 1 1 1000000
// same-cycle pairing while locked
01 150 250 1 1 250150
04 160 260 1 1 260160
// flag flip, the flip cycle pairs the held rise word
01 170 270 0 1 270163
// requalification with the flag low
0E 300 400 0 1 1000000
01 500 600 0 1 60030D
03 510 610 0 1 610500
// long ready-low stretch fills the buffer
0A 700 800 0 0 800512
// drain
08 900 A00 0 1 A00709
// flip back to high
06 B00 C00 1 1 C00B00
